/* sim.f */
verilog/bpu_cfg_pkg.sv
verilog/la_isa_pkg.sv
verilog/predecoder.sv
verilog/gshare_pht.sv
verilog/local_bht.sv
verilog/btb.sv
verilog/bpu_d.sv
verification/bpu_props.sv
verification/tb_bpu.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_bpu -f sim.f -o sim_bpu
	./obj_dir/sim_bpu | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

/* verification/tb_bpu.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_bpu import la_isa_pkg::*; ();

    localparam int HIST_W    = 8;
    localparam int NUM_TESTS = 6;
    localparam int CLK_PER   = 8;

    logic                   clk;
    logic                   rst;
    logic                   stall;
    logic [1:0][31:0]       pc;
    logic [1:0][31:0]       inst;
    logic [1:0]             inst_en;
    logic                   upd_en;
    logic [31:0]            upd_pc;
    logic                   upd_taken;
    logic [HIST_W-1:0]      upd_ghr;
    logic [31:0]            upd_target;
    logic [1:0]             is_branch;
    logic [1:0]             taken;
    logic [31:0]            target;
    logic [HIST_W-1:0]      ghr;
    logic [1:0]             fetch_en;
    logic                   flush;

    int errors;
    int test_errors; // error count when the current test began
    int tests_run;
    int tests_failed;

    bpu_d #(.HIST_W(HIST_W), .BTB_ENTRIES(64)) i_bpu_d (
        .clk             (clk),
        .rst             (rst),
        .stall_i         (stall),
        .pc_i            (pc),
        .inst_i          (inst),
        .inst_en_i       (inst_en),
        .update_en_i     (upd_en),
        .update_pc_i     (upd_pc),
        .update_taken_i  (upd_taken),
        .update_ghr_i    (upd_ghr),
        .update_target_i (upd_target),
        .is_branch_o     (is_branch),
        .taken_o         (taken),
        .target_o        (target),
        .ghr_o           (ghr),
        .fetch_en_o      (fetch_en),
        .bpu_flush_o     (flush)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PER / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * 50 * CLK_PER);
        $display("timeout: tests did not complete within %0d cycles", NUM_TESTS * 50);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_inputs();
        stall      = 1'b0;
        pc         = '0;
        inst       = '0;
        inst_en    = '0;
        upd_en     = 1'b0;
        upd_pc     = '0;
        upd_taken  = 1'b0;
        upd_ghr    = '0;
        upd_target = '0;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        idle_inputs();
        repeat (8) step();
        rst = 1'b0;
    endtask

    // outputs of the predict stage are valid after the next edge
    task automatic present(input logic [31:0] pc0, input logic [31:0] inst0,
                           input logic [31:0] pc1, input logic [31:0] inst1,
                           input logic [1:0] en, input logic stl);
        pc[0]   = pc0;
        pc[1]   = pc1;
        inst[0] = inst0;
        inst[1] = inst1;
        inst_en = en;
        stall   = stl;
        step();
        idle_inputs();
    endtask

    task automatic apply_update(input logic [31:0] upc, input logic utaken,
                                input logic [HIST_W-1:0] ughr, input logic [31:0] utgt);
        upd_en     = 1'b1;
        upd_pc     = upc;
        upd_taken  = utaken;
        upd_ghr    = ughr;
        upd_target = utgt;
        step();
        idle_inputs();
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_errors = errors;
        apply_reset();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_errors);
        end
    endtask

    function automatic logic [31:0] enc_i26(input logic [5:0] op, input logic [25:0] offs);
        inst_word_u w;
        w             = '0;
        w.i26.opcode  = op;
        w.i26.offs_lo = offs[15:0];
        w.i26.offs_hi = offs[25:16];
        return w;
    endfunction

    function automatic logic [31:0] enc_i16(input logic [5:0] op, input logic [15:0] offs,
                                            input logic [4:0] rj, input logic [4:0] rd);
        inst_word_u w;
        w            = '0;
        w.i16.opcode = op;
        w.i16.offs16 = offs;
        w.i16.rj     = rj;
        w.i16.rd     = rd;
        return w;
    endfunction

    function automatic logic [31:0] rand_pc();
        return $urandom() & 32'hffff_fffc;
    endfunction

    // major opcode 0, never a branch
    function automatic logic [31:0] rand_plain();
        return $urandom() & 32'h03ff_ffff;
    endfunction

    initial begin
        logic [31:0]       p0;
        logic [31:0]       t_btb;
        logic [31:0]       tgt_exp;
        logic [25:0]       o26;
        logic [15:0]       o16;
        logic [HIST_W-1:0] g_upd;
        logic [HIST_W-1:0] g_rep;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(54));

        begin_test();
        p0 = rand_pc();
        present(p0, rand_plain(), p0 + 4, rand_plain(), 2'b11, 1'b0);
        check_val("is_branch_o", 32'(is_branch), 32'h0);
        check_val("taken_o", 32'(taken), 32'h0);
        check_val("bpu_flush_o", 32'(flush), 32'h0);
        check_val("fetch_en_o", 32'(fetch_en), 32'h3);
        check_val("ghr_o", 32'(ghr), 32'h0);
        end_test("idle after reset");

        begin_test();
        p0  = rand_pc();
        o26 = 26'($urandom());
        o16 = 16'($urandom());
        tgt_exp = p0 + 32'(int'($signed(o26)) * 4);
        present(p0, enc_i26(OP_B, o26), p0 + 4, enc_i16(OP_BEQ, o16, 5'd1, 5'd2), 2'b11, 1'b0);
        check_val("is_branch_o", 32'(is_branch), 32'h3);
        check_val("taken_o", 32'(taken), 32'h1);
        check_val("bpu_flush_o", 32'(flush), 32'h1);
        check_val("fetch_en_o", 32'(fetch_en), 32'h1);
        check_val("target_o", target, tgt_exp);
        end_test("b in slot 0");

        begin_test();
        p0  = rand_pc();
        o16 = 16'($urandom());
        tgt_exp = p0 + 4 + 32'(int'($signed(o16)) * 4);
        present(p0, rand_plain(), p0 + 4, enc_i16(OP_BNE, o16, 5'd3, 5'd4), 2'b11, 1'b0);
        check_val("taken_o", 32'(taken), 32'h2);
        check_val("bpu_flush_o", 32'(flush), 32'h1);
        check_val("fetch_en_o", 32'(fetch_en), 32'h3);
        check_val("target_o", target, tgt_exp);
        step();
        check_val("ghr_o", 32'(ghr), 32'h1); // taken shifted into empty history
        end_test("conditional in slot 1");

        begin_test();
        p0 = rand_pc();
        apply_update(p0, 1'b0, '0, 32'h0);
        apply_update(p0, 1'b0, '0, 32'h0);
        present(p0, enc_i16(OP_BLT, 16'($urandom()), 5'd5, 5'd6), p0 + 4, 32'h0, 2'b01, 1'b0);
        check_val("is_branch_o", 32'(is_branch), 32'h1);
        check_val("taken_o", 32'(taken), 32'h0);
        check_val("bpu_flush_o", 32'(flush), 32'h0);
        step();
        check_val("ghr_o", 32'(ghr), 32'h0);
        end_test("trained not taken");

        begin_test();
        p0    = rand_pc();
        t_btb = rand_pc();
        present(p0, enc_i16(OP_JIRL, 16'($urandom()), 5'd1, 5'd0), p0 + 4, 32'h0, 2'b01, 1'b0);
        check_val("is_branch_o", 32'(is_branch), 32'h1);
        check_val("taken_o", 32'(taken), 32'h0);
        check_val("bpu_flush_o", 32'(flush), 32'h0);
        apply_update(p0, 1'b1, '0, t_btb);
        present(p0, enc_i16(OP_JIRL, 16'($urandom()), 5'd1, 5'd0), p0 + 4, 32'h0, 2'b01, 1'b0);
        check_val("taken_o", 32'(taken), 32'h1);
        check_val("bpu_flush_o", 32'(flush), 32'h1);
        check_val("fetch_en_o", 32'(fetch_en), 32'h1);
        check_val("target_o", target, t_btb);
        end_test("jirl through btb");

        begin_test();
        g_upd    = HIST_W'($urandom());
        g_upd[0] = 1'b0;
        g_rep    = {g_upd[HIST_W-1:1], 1'b1};
        apply_update(rand_pc(), 1'b1, g_upd, rand_pc());
        p0 = rand_pc();
        // only taken updates so far, every counter still says taken
        present(p0, enc_i16(OP_BGE, 16'($urandom()), 5'd7, 5'd8), p0 + 4, 32'h0, 2'b01, 1'b0);
        check_val("taken_o", 32'(taken), 32'h1);
        check_val("bpu_flush_o", 32'(flush), 32'h1);
        step();
        check_val("ghr_o", 32'(ghr), 32'({g_rep[HIST_W-2:0], 1'b1}));
        step();
        present(p0, enc_i26(OP_B, 26'($urandom())), p0 + 4, 32'h0, 2'b01, 1'b1);
        check_val("is_branch_o", 32'(is_branch), 32'h0);
        check_val("taken_o", 32'(taken), 32'h0);
        check_val("bpu_flush_o", 32'(flush), 32'h0);
        end_test("history repair and stall");

        if (i_bpu_d.i_bpu_props.fail_count != 0) begin
            $display("bound assertions on the DUT outputs failed %0d times",
                     i_bpu_d.i_bpu_props.fail_count);
            errors += i_bpu_d.i_bpu_props.fail_count;
        end

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/bpu_props.sv */
`timescale 1ns/1ns
`default_nettype none

module bpu_props #(
    parameter int HIST_W = 8
) (
    input logic              clk,
    input logic              rst,
    input logic [1:0]        taken_i,
    input logic [1:0]        fetch_en_i,
    input logic              flush_i,
    input logic [HIST_W-1:0] ghr_i
);

    int fail_count = 0;

    a_flush_is_any_taken: assert property (
        @(posedge clk) disable iff (rst) flush_i == |taken_i
    ) else begin
        $error("bpu_flush_o differs from the or of taken_o");
        fail_count++;
    end

    // slot 0 wins, never both
    a_taken_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(taken_i)
    ) else begin
        $error("taken_o has more than one slot set");
        fail_count++;
    end

    a_fetch_en_legal: assert property (
        @(posedge clk) disable iff (rst) fetch_en_i != 2'b10
    ) else begin
        $error("fetch_en_o drops slot 0 and keeps slot 1");
        fail_count++;
    end

    a_ghr_cleared: assert property (
        @(posedge clk) rst |=> ghr_i == '0
    ) else begin
        $error("ghr_o not zero after reset");
        fail_count++;
    end

endmodule

bind bpu_d bpu_props #(.HIST_W(HIST_W)) i_bpu_props (
    .clk        (clk),
    .rst        (rst),
    .taken_i    (taken_o),
    .fetch_en_i (fetch_en_o),
    .flush_i    (bpu_flush_o),
    .ghr_i      (ghr_o)
);

`default_nettype wire

/* verilog/bpu_d.sv */
`timescale 1ns/1ns
`default_nettype none

module bpu_d import la_isa_pkg::*; #(
    parameter int HIST_W      = 8,
    parameter int BTB_ENTRIES = 64
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall_i,
    input  logic [1:0][31:0] pc_i,
    input  logic [1:0][31:0] inst_i,
    input  logic [1:0]       inst_en_i,

    input  logic             update_en_i,
    input  logic [31:0]      update_pc_i,
    input  logic             update_taken_i,
    input  logic [HIST_W-1:0] update_ghr_i,
    input  logic [31:0]      update_target_i,

    output logic [1:0]       is_branch_o,
    output logic [1:0]       taken_o,
    output logic [31:0]      target_o,
    output logic [HIST_W-1:0] ghr_o,
    output logic [1:0]       fetch_en_o,
    output logic             bpu_flush_o
);

    logic [HIST_W-1:0]      ghr_q;
    logic [1:0][HIST_W-1:0] gsh_idx_q;
    logic [HIST_W-1:0]      gsh_upd_idx;
    logic [1:0]             en_q;
    logic                   flush_q;
    logic                   squash;

    logic [1:0][31:0] pd_inst;
    br_class_t        pd_class [2];
    logic [1:0][31:0] pd_tgt;
    logic [1:0]       gsh_taken;
    logic [1:0]       loc_taken;
    logic [1:0]       btb_hit;
    logic [1:0][31:0] btb_tgt;

    logic [1:0]       slot_tk;
    logic [1:0][31:0] slot_tgt;
    logic             spec_shift;
    logic             spec_dir;

    // wrong path after a taken slot, or frozen fetch
    assign squash  = stall_i || bpu_flush_o || flush_q;
    assign pd_inst = squash ? '0 : inst_i;

    assign gsh_upd_idx = update_ghr_i ^ update_pc_i[HIST_W+1:2];

    always_ff @(posedge clk) begin
        for (int s = 0; s < 2; s++) begin
            gsh_idx_q[s] <= ghr_q ^ pc_i[s][HIST_W+1:2];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            en_q    <= '0;
            flush_q <= 1'b0;
        end else begin
            en_q    <= inst_en_i;
            flush_q <= bpu_flush_o;
        end
    end

    for (genvar s = 0; s < 2; s++) begin : g_pd
        predecoder u_predecoder (
            .clk      (clk),
            .rst      (rst),
            .inst_i   (pd_inst[s]),
            .pc_i     (pc_i[s]),
            .class_o  (pd_class[s]),
            .target_o (pd_tgt[s])
        );
    end

    gshare_pht #(.HIST_W(HIST_W)) u_gshare_pht (
        .clk         (clk),
        .rst         (rst),
        .idx_i       (gsh_idx_q),
        .upd_en_i    (update_en_i),
        .upd_idx_i   (gsh_upd_idx),
        .upd_taken_i (update_taken_i),
        .taken_o     (gsh_taken)
    );

    local_bht #(.HIST_W(HIST_W)) u_local_bht (
        .clk         (clk),
        .rst         (rst),
        .pc_i        (pc_i),
        .upd_en_i    (update_en_i),
        .upd_pc_i    (update_pc_i),
        .upd_taken_i (update_taken_i),
        .taken_o     (loc_taken)
    );

    btb #(.BTB_ENTRIES(BTB_ENTRIES)) u_btb (
        .clk          (clk),
        .rst          (rst),
        .pc_i         (pc_i),
        .upd_en_i     (update_en_i),
        .upd_taken_i  (update_taken_i),
        .upd_pc_i     (update_pc_i),
        .upd_target_i (update_target_i),
        .hit_o        (btb_hit),
        .target_o     (btb_tgt)
    );

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            is_branch_o[s] = en_q[s] && pd_class[s] != BR_NONE;
            // no chooser, both tables must agree on taken
            slot_tk[s] = en_q[s] && ((pd_class[s] == BR_DIRECT)
                      || (pd_class[s] == BR_COND && gsh_taken[s] && loc_taken[s])
                      || (pd_class[s] == BR_INDIRECT && btb_hit[s]));
            slot_tgt[s] = (pd_class[s] == BR_INDIRECT) ? btb_tgt[s] : pd_tgt[s];
        end
    end

    always_comb begin
        taken_o    = 2'b00;
        target_o   = '0;
        fetch_en_o = 2'b11;
        if (slot_tk[0]) begin
            taken_o    = 2'b01;
            target_o   = slot_tgt[0];
            fetch_en_o = 2'b01; // drop slot 1
        end else if (slot_tk[1]) begin
            taken_o  = 2'b10;
            target_o = slot_tgt[1];
        end
    end

    assign bpu_flush_o = |taken_o;

    // first predicted branch feeds the history
    assign spec_shift = |is_branch_o;
    assign spec_dir   = is_branch_o[0] ? slot_tk[0] : slot_tk[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            ghr_q <= '0;
            ghr_o <= '0;
        end else if (update_en_i) begin
            if (update_taken_i != update_ghr_i[0]) begin // mispredict repair
                ghr_q <= {update_ghr_i[HIST_W-1:1], update_taken_i};
            end
        end else if (spec_shift) begin
            ghr_q <= {ghr_q[HIST_W-2:0], spec_dir};
            ghr_o <= {ghr_q[HIST_W-2:0], spec_dir};
        end
    end

endmodule

`default_nettype wire

/* verilog/btb.sv */
`timescale 1ns/1ns
`default_nettype none

module btb #(
    parameter int BTB_ENTRIES = 64
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [1:0][31:0] pc_i,
    input  logic             upd_en_i,
    input  logic             upd_taken_i,
    input  logic [31:0]      upd_pc_i,
    input  logic [31:0]      upd_target_i,
    output logic [1:0]       hit_o,
    output logic [1:0][31:0] target_o
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = 30 - IDX_W; // pc[1:0] always zero

    logic             valid_q [BTB_ENTRIES];
    logic [TAG_W-1:0] tag_q   [BTB_ENTRIES];
    logic [31:0]      tgt_q   [BTB_ENTRIES];

    logic             wr_en;
    logic [IDX_W-1:0] upd_idx;
    logic [TAG_W-1:0] upd_tag;

    assign wr_en   = upd_en_i && upd_taken_i;
    assign upd_idx = upd_pc_i[IDX_W+1:2];
    assign upd_tag = upd_pc_i[31:IDX_W+2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[upd_idx] <= upd_tag;
            tgt_q[upd_idx] <= upd_target_i;
        end
    end

    // registered lookup, lines up with the counter tables
    always_ff @(posedge clk) begin
        if (rst) begin
            hit_o <= '0;
        end else begin
            for (int s = 0; s < 2; s++) begin
                hit_o[s] <= valid_q[pc_i[s][IDX_W+1:2]]
                         && tag_q[pc_i[s][IDX_W+1:2]] == pc_i[s][31:IDX_W+2];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < 2; s++) begin
            target_o[s] <= tgt_q[pc_i[s][IDX_W+1:2]];
        end
    end

endmodule

`default_nettype wire

/* verilog/local_bht.sv */
`timescale 1ns/1ns
`default_nettype none

module local_bht import bpu_cfg_pkg::*; #(
    parameter int HIST_W = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [1:0][31:0] pc_i,
    input  logic             upd_en_i,
    input  logic [31:0]      upd_pc_i,
    input  logic             upd_taken_i,
    output logic [1:0]       taken_o
);

    localparam int ENTRIES = 2**HIST_W;

    logic [HIST_W-1:0] lhist [ENTRIES]; // per-pc history
    ctr_t              lpht  [ENTRIES];

    logic [1:0][HIST_W-1:0] idx_q;
    logic [HIST_W-1:0]      upd_pc_idx;
    logic [HIST_W-1:0]      upd_idx;

    assign upd_pc_idx = upd_pc_i[HIST_W+1:2];
    assign upd_idx    = lhist[upd_pc_idx] ^ upd_pc_idx; // pre-shift history

    always_ff @(posedge clk) begin
        for (int s = 0; s < 2; s++) begin
            idx_q[s] <= lhist[pc_i[s][HIST_W+1:2]] ^ pc_i[s][HIST_W+1:2];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                lhist[i] <= '0;
                lpht[i]  <= CTR_WEAK_TAKEN;
            end
        end else if (upd_en_i) begin
            lpht[upd_idx]     <= ctr_step(lpht[upd_idx], upd_taken_i);
            lhist[upd_pc_idx] <= {lhist[upd_pc_idx][HIST_W-2:0], upd_taken_i};
        end
    end

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            taken_o[s] = lpht[idx_q[s]][1];
        end
    end

endmodule

`default_nettype wire

/* verilog/gshare_pht.sv */
`timescale 1ns/1ns
`default_nettype none

module gshare_pht import bpu_cfg_pkg::*; #(
    parameter int HIST_W = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [1:0][HIST_W-1:0] idx_i,
    input  logic                   upd_en_i,
    input  logic [HIST_W-1:0]      upd_idx_i,
    input  logic                   upd_taken_i,
    output logic [1:0]             taken_o
);

    localparam int ENTRIES = 2**HIST_W;

    ctr_t pht [ENTRIES];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                pht[i] <= CTR_WEAK_TAKEN;
            end
        end else if (upd_en_i) begin
            pht[upd_idx_i] <= ctr_step(pht[upd_idx_i], upd_taken_i);
        end
    end

    // index already registered in the top level
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            taken_o[s] = pht[idx_i[s]][1];
        end
    end

endmodule

`default_nettype wire

/* verilog/predecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module predecoder import la_isa_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] inst_i,
    input  logic [31:0] pc_i,
    output br_class_t   class_o,
    output logic [31:0] target_o
);

    inst_word_u  word;
    logic [25:0] offs26;
    br_class_t   cls;
    logic [31:0] tgt;

    assign word   = inst_i;
    assign offs26 = {word.i26.offs_hi, word.i26.offs_lo};

    always_comb begin
        cls = BR_NONE;
        tgt = '0;
        case (word.i16.opcode)
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                cls = BR_COND;
                tgt = pc_i + {{14{word.i16.offs16[15]}}, word.i16.offs16, 2'b00};
            end
            OP_B, OP_BL: begin
                cls = BR_DIRECT;
                tgt = pc_i + {{4{offs26[25]}}, offs26, 2'b00};
            end
            OP_JIRL: begin
                cls = BR_INDIRECT; // target comes from the btb
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            class_o <= BR_NONE;
        end else begin
            class_o <= cls;
        end
    end

    always_ff @(posedge clk) begin
        target_o <= tgt;
    end

endmodule

`default_nettype wire

/* verilog/la_isa_pkg.sv */
`default_nettype none

package la_isa_pkg;

    // 6-bit major opcodes, inst[31:26]
    localparam logic [5:0] OP_JIRL = 6'h13;
    localparam logic [5:0] OP_B    = 6'h14;
    localparam logic [5:0] OP_BL   = 6'h15;
    localparam logic [5:0] OP_BEQ  = 6'h16;
    localparam logic [5:0] OP_BNE  = 6'h17;
    localparam logic [5:0] OP_BLT  = 6'h18;
    localparam logic [5:0] OP_BGE  = 6'h19;
    localparam logic [5:0] OP_BLTU = 6'h1a;
    localparam logic [5:0] OP_BGEU = 6'h1b;

    typedef enum logic [1:0] {
        BR_NONE     = 2'd0,
        BR_COND     = 2'd1, // beq .. bgeu
        BR_DIRECT   = 2'd2, // b, bl
        BR_INDIRECT = 2'd3  // jirl
    } br_class_t;

    // conditional branches and jirl
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_i16_t;

    // b and bl, offset split across the word
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } inst_i26_t;

    typedef union packed {
        inst_i16_t i16;
        inst_i26_t i26;
    } inst_word_u;

endpackage

`default_nettype wire

/* verilog/bpu_cfg_pkg.sv */
`default_nettype none

package bpu_cfg_pkg;

    typedef logic [1:0] ctr_t; // 2-bit saturating counter, msb is the direction

    localparam ctr_t CTR_STRONG_NT    = 2'b00;
    localparam ctr_t CTR_WEAK_TAKEN   = 2'b10; // reset value of every table entry
    localparam ctr_t CTR_STRONG_TAKEN = 2'b11;

    // one step toward the resolved outcome, saturating at both ends
    function automatic ctr_t ctr_step(input ctr_t ctr, input logic taken);
        ctr_t nxt;
        nxt = ctr;
        if (taken && ctr != CTR_STRONG_TAKEN) begin
            nxt = ctr + 2'd1;
        end else if (!taken && ctr != CTR_STRONG_NT) begin
            nxt = ctr - 2'd1;
        end
        return nxt;
    endfunction

endpackage

`default_nettype wire
